// ==== source/ft601_pkg.sv ====
package ft601_pkg;

    // FT601 bus in 245 synchronous FIFO mode, 32-bit variant
    localparam int DATA_W = 32;
    localparam int BE_W = 4;            // one enable per data byte

    // buffer word, byte enables sit above the data
    localparam int WORD_W = DATA_W + BE_W;

    // packet buffer depth in words
    // kept small so the buffer fills quickly in simulation
    localparam int BUF_DEPTH = 256;

    localparam int PTR_W = $clog2(BUF_DEPTH);   // address bits
    localparam int CNT_W = PTR_W + 1;           // pointer and count width, wrap bit on top

    // count at which almost_unwriteable rises and the packet closes itself
    localparam int AFULL_LEVEL = BUF_DEPTH - 1;

endpackage

// ==== source/cdc_sync_bit.sv ====
`timescale 1ns/1ps

module cdc_sync_bit #(
    parameter bit NEG_EDGE = 1'b0   // capture on the falling edge of clk
) (
    input  logic clk,
    input  logic src_in,
    output logic dest_out
);

    logic cap_clk;

    // synchronizer chain, stage 0 may go metastable
    (* async_reg = "true" *) logic [1:0] sync_q;

    assign cap_clk = NEG_EDGE ? ~clk : clk;     // rd side samples on the falling edge

    always_ff @(posedge cap_clk) begin
        sync_q <= {sync_q[0], src_in};
    end

    assign dest_out = sync_q[1];

    // output only follows the input as it was two captures earlier
    a_sync_two_stage: assert property (@(posedge cap_clk)
        (!$isunknown({dest_out, $past(dest_out)}) && $changed(dest_out))
            |-> ($past(src_in, 2) != $past(dest_out)));

endmodule

// ==== source/async_fifo.sv ====
`timescale 1ns/1ps

module async_fifo (
    // write side
    input  logic                           wr_clk,
    input  logic                           wr_reset,
    input  logic                           wr_en,
    input  logic [ft601_pkg::WORD_W-1:0]   din,
    output logic                           full,
    output logic                           almost_full,
    output logic [ft601_pkg::CNT_W-1:0]    wr_count,

    // read side, runs on the falling edge of rd_clk
    input  logic                           rd_clk,
    input  logic                           rd_reset,
    input  logic                           rd_en,
    output logic [ft601_pkg::WORD_W-1:0]   dout,
    output logic                           valid,
    output logic                           empty
);

    logic [ft601_pkg::WORD_W-1:0] mem [ft601_pkg::BUF_DEPTH];

    logic                        wr_fire;
    logic [ft601_pkg::CNT_W-1:0] wr_bin;
    logic [ft601_pkg::CNT_W-1:0] wr_bin_next;
    logic [ft601_pkg::CNT_W-1:0] wr_gray;

    logic                        rd_fire;
    logic [ft601_pkg::CNT_W-1:0] rd_bin;
    logic [ft601_pkg::CNT_W-1:0] rd_bin_next;
    logic [ft601_pkg::CNT_W-1:0] rd_gray;

    // gray pointers crossing into the other domain
    (* async_reg = "true" *) logic [ft601_pkg::CNT_W-1:0] rd_gray_w1;
    (* async_reg = "true" *) logic [ft601_pkg::CNT_W-1:0] rd_gray_w2;
    (* async_reg = "true" *) logic [ft601_pkg::CNT_W-1:0] wr_gray_r1;
    (* async_reg = "true" *) logic [ft601_pkg::CNT_W-1:0] wr_gray_r2;

    function automatic logic [ft601_pkg::CNT_W-1:0] bin2gray(
        input logic [ft601_pkg::CNT_W-1:0] b
    );
        return b ^ (b >> 1);
    endfunction

    function automatic logic [ft601_pkg::CNT_W-1:0] gray2bin(
        input logic [ft601_pkg::CNT_W-1:0] g
    );
        logic [ft601_pkg::CNT_W-1:0] b;
        b[ft601_pkg::CNT_W-1] = g[ft601_pkg::CNT_W-1];
        for (int i = ft601_pkg::CNT_W - 2; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // write domain
    assign wr_fire = wr_en && !full;    // an overflowing write is dropped
    assign wr_bin_next = wr_bin + ft601_pkg::CNT_W'(wr_fire);

    always_ff @(posedge wr_clk) begin
        if (wr_fire) begin
            mem[wr_bin[ft601_pkg::PTR_W-1:0]] <= din;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_reset) begin
            wr_bin <= '0;
            wr_gray <= '0;
            rd_gray_w1 <= '0;
            rd_gray_w2 <= '0;
        end else begin
            wr_bin <= wr_bin_next;
            wr_gray <= bin2gray(wr_bin_next);   // registered so the crossing value never glitches
            rd_gray_w1 <= rd_gray;
            rd_gray_w2 <= rd_gray_w1;
        end
    end

    // count is pessimistic, the read pointer seen here lags
    assign wr_count = wr_bin - gray2bin(rd_gray_w2);
    assign full = (wr_count == ft601_pkg::CNT_W'(ft601_pkg::BUF_DEPTH));
    assign almost_full = (wr_count >= ft601_pkg::CNT_W'(ft601_pkg::AFULL_LEVEL));

    // read domain
    assign empty = (rd_gray == wr_gray_r2);
    assign valid = !empty;
    assign rd_fire = rd_en && !empty;
    assign rd_bin_next = rd_bin + ft601_pkg::CNT_W'(rd_fire);

    always_ff @(negedge rd_clk) begin
        if (rd_reset) begin
            rd_bin <= '0;
            rd_gray <= '0;
            wr_gray_r1 <= '0;
            wr_gray_r2 <= '0;
        end else begin
            rd_bin <= rd_bin_next;
            rd_gray <= bin2gray(rd_bin_next);
            wr_gray_r1 <= wr_gray;
            wr_gray_r2 <= wr_gray_r1;
        end
    end

    assign dout = mem[rd_bin[ft601_pkg::PTR_W-1:0]];  // head word, first word fall through

    a_no_write_full: assert property (@(posedge wr_clk) disable iff (wr_reset)
        wr_en |-> !full);

    a_no_read_empty: assert property (@(negedge rd_clk) disable iff (rd_reset)
        rd_en |-> !empty);

endmodule

// ==== source/ft601_wr_buf.sv ====
`timescale 1ns/1ps

module ft601_wr_buf (
    // user side
    input  logic                           wr_clk,
    input  logic                           wr_reset,
    input  logic [ft601_pkg::WORD_W-1:0]   wr_data,
    input  logic                           wr_ce,
    input  logic                           wr_en,
    input  logic                           wr_push,
    output logic                           writeable,
    output logic                           almost_unwriteable,
    output logic                           wr_afull,

    // FT601 side on the falling edge of rd_clk
    input  logic                           rd_clk,
    input  logic                           rd_reset,
    input  logic                           rd_en,
    output logic [ft601_pkg::WORD_W-1:0]   rd_data,
    output logic                           rd_valid,
    output logic                           readable
);

    logic                        wr_accept;
    logic                        close_pkt;
    logic [ft601_pkg::CNT_W-1:0] wr_cnt;    // words in the open packet

    logic rd_empty;
    logic rd_done;          // rd_empty seen in wr_clk
    logic rd_done_q;
    logic done_rise;
    logic rd_pending;       // closed packet as seen in the rd domain
    logic rd_pending_q;

    assign wr_accept = wr_en && wr_ce;

    // push or a write that reaches the almost-full level ends the packet
    assign close_pkt = wr_ce && (wr_push ||
        (wr_en && wr_cnt >= ft601_pkg::CNT_W'(ft601_pkg::AFULL_LEVEL - 1)));

    assign almost_unwriteable = (wr_cnt >= ft601_pkg::CNT_W'(ft601_pkg::AFULL_LEVEL));
    assign done_rise = rd_done && !rd_done_q;   // FT601 side drained the packet

    always_ff @(posedge wr_clk) begin
        if (wr_reset) begin
            writeable <= 1'b1;
            wr_cnt <= '0;
            rd_done_q <= 1'b0;
        end else begin
            rd_done_q <= rd_done;
            if (close_pkt) begin
                writeable <= 1'b0;
            end else if (done_rise) begin
                writeable <= 1'b1;
            end
            if (wr_accept) begin
                wr_cnt <= wr_cnt + ft601_pkg::CNT_W'(1);
            end else if (done_rise) begin
                wr_cnt <= '0;           // next packet starts from zero
            end
        end
    end

    async_fifo fifo_i (
        .wr_clk      (wr_clk),
        .wr_reset    (wr_reset),
        .wr_en       (wr_accept),
        .din         (wr_data),
        .full        (),
        .almost_full (wr_afull),
        .wr_count    (),
        .rd_clk      (rd_clk),
        .rd_reset    (rd_reset),
        .rd_en       (rd_en),
        .dout        (rd_data),
        .valid       (rd_valid),
        .empty       (rd_empty)
    );

    cdc_sync_bit #(.NEG_EDGE(1'b1)) ready_sync (
        .clk      (rd_clk),
        .src_in   (!writeable),
        .dest_out (rd_pending)
    );

    cdc_sync_bit #(.NEG_EDGE(1'b0)) done_sync (
        .clk      (wr_clk),
        .src_in   (rd_empty),
        .dest_out (rd_done)
    );

    // readable opens on a new closed packet and shuts once the FIFO runs dry
    always_ff @(negedge rd_clk) begin
        if (rd_reset) begin
            rd_pending_q <= 1'b0;
            readable <= 1'b0;
        end else begin
            rd_pending_q <= rd_pending;
            if (rd_pending && !rd_pending_q) begin
                readable <= 1'b1;
            end else if (rd_empty) begin
                readable <= 1'b0;
            end
        end
    end

    a_no_write_closed: assert property (@(posedge wr_clk) disable iff (wr_reset)
        wr_accept |-> writeable);

    // writeable must stay up two cycles or ready_sync can miss the low gap
    a_wr_holdoff: assert property (@(posedge wr_clk) disable iff (wr_reset)
        $rose(writeable) |-> !close_pkt);

endmodule

// ==== source/ft601_tx_ctrl.sv ====
`timescale 1ns/1ps

module ft601_tx_ctrl (
    input  logic                           rd_clk,
    input  logic                           rd_reset,
    input  logic                           readable,
    input  logic [ft601_pkg::WORD_W-1:0]   rd_data,
    input  logic                           rd_valid,
    output logic                           rd_en,
    input  logic                           ft_txe_n,
    output logic                           ft_wr_n,
    output logic [ft601_pkg::DATA_W-1:0]   ft_data,
    output logic [ft601_pkg::BE_W-1:0]     ft_be
);

    logic tx_arm;   // bus may be driven this cycle
    logic ft_acc;   // FT601 took the word at the last rising edge

    // arm on the falling edge, drops one edge after txe_n goes high
    always_ff @(negedge rd_clk) begin
        if (rd_reset) begin
            tx_arm <= 1'b0;
        end else begin
            tx_arm <= readable && rd_valid && !ft_txe_n;
        end
    end

    // wr_n lifts straight after the pop of the last word
    assign ft_wr_n = !(tx_arm && rd_valid);

    // the transfer happens at the rising edge, so acceptance is caught there
    // and txe_n moving after that edge cannot cause a lost or doubled pop
    always_ff @(posedge rd_clk) begin
        if (rd_reset) begin
            ft_acc <= 1'b0;
        end else begin
            ft_acc <= !ft_txe_n && !ft_wr_n;
        end
    end

    assign rd_en = ft_acc;      // popped at the following falling edge

    // head word straight onto the pins, held while stalled
    assign ft_data = rd_data[ft601_pkg::DATA_W-1:0];
    assign ft_be = rd_data[ft601_pkg::WORD_W-1:ft601_pkg::DATA_W];

endmodule

// ==== source/ft601_tx_top.sv ====
`timescale 1ns/1ps

module ft601_tx_top (
    // user write port
    input  logic                           wr_clk,
    input  logic                           wr_reset,
    input  logic [ft601_pkg::WORD_W-1:0]   wr_data,
    input  logic                           wr_ce,
    input  logic                           wr_en,
    input  logic                           wr_push,
    output logic                           writeable,
    output logic                           almost_unwriteable,
    output logic                           wr_afull,

    // FT601 pins
    input  logic                           rd_clk,
    input  logic                           rd_reset,
    input  logic                           ft_txe_n,
    output logic                           ft_wr_n,
    output logic [ft601_pkg::DATA_W-1:0]   ft_data,
    output logic [ft601_pkg::BE_W-1:0]     ft_be
);

    logic                         rd_en;
    logic [ft601_pkg::WORD_W-1:0] rd_data;
    logic                         rd_valid;
    logic                         readable;

    ft601_wr_buf buf_i (
        .wr_clk             (wr_clk),
        .wr_reset           (wr_reset),
        .wr_data            (wr_data),
        .wr_ce              (wr_ce),
        .wr_en              (wr_en),
        .wr_push            (wr_push),
        .writeable          (writeable),
        .almost_unwriteable (almost_unwriteable),
        .wr_afull           (wr_afull),
        .rd_clk             (rd_clk),
        .rd_reset           (rd_reset),
        .rd_en              (rd_en),
        .rd_data            (rd_data),
        .rd_valid           (rd_valid),
        .readable           (readable)
    );

    ft601_tx_ctrl tx_i (
        .rd_clk   (rd_clk),
        .rd_reset (rd_reset),
        .readable (readable),
        .rd_data  (rd_data),
        .rd_valid (rd_valid),
        .rd_en    (rd_en),
        .ft_txe_n (ft_txe_n),
        .ft_wr_n  (ft_wr_n),
        .ft_data  (ft_data),
        .ft_be    (ft_be)
    );

endmodule

// ==== test/ft601_tx_tb.sv ====
`timescale 1ns/1ps

module ft601_tx_tb;

    localparam int WR_PERIOD = 8;
    localparam int RD_PERIOD = 10;
    localparam int RESET_CYCLES = 8;
    localparam int BURST_PKTS = 8;      // back to back packets in the last test
    localparam int MARGIN_NS = 5000;    // sync latency and reset on top of the word time

    logic wr_clk = 1'b0;
    logic rd_clk = 1'b0;
    logic wr_reset;
    logic rd_reset;
    logic [ft601_pkg::WORD_W-1:0] wr_data;
    logic wr_ce;
    logic wr_en;
    logic wr_push;
    logic writeable;
    logic almost_unwriteable;
    logic wr_afull;
    logic ft_txe_n;
    logic ft_wr_n;
    logic [ft601_pkg::DATA_W-1:0] ft_data;
    logic [ft601_pkg::BE_W-1:0] ft_be;

    logic [31:0] lfsr = 32'he6d;
    logic [ft601_pkg::WORD_W-1:0] exp_q [$];   // written but not yet seen on the bus
    logic [ft601_pkg::WORD_W-1:0] exp_word;
    int pkt_len [$];
    int total_words = 0;
    int words_seen = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int budget_ns = 0;
    logic stall_en;
    logic txe_at_fall;                  // txe_n as the controller saw it

    ft601_tx_top dut (
        .wr_clk             (wr_clk),
        .wr_reset           (wr_reset),
        .wr_data            (wr_data),
        .wr_ce              (wr_ce),
        .wr_en              (wr_en),
        .wr_push            (wr_push),
        .writeable          (writeable),
        .almost_unwriteable (almost_unwriteable),
        .wr_afull           (wr_afull),
        .rd_clk             (rd_clk),
        .rd_reset           (rd_reset),
        .ft_txe_n           (ft_txe_n),
        .ft_wr_n            (ft_wr_n),
        .ft_data            (ft_data),
        .ft_be              (ft_be)
    );

    always #(WR_PERIOD / 2) wr_clk = ~wr_clk;

    // quarter period offset keeps rd edges clear of wr edges
    always begin
        #(RD_PERIOD / 4.0);
        rd_clk = 1'b1;
        #(RD_PERIOD / 2.0);
        rd_clk = 1'b0;
        #(RD_PERIOD / 4.0);
    end

    // 32-bit Fibonacci with taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int nbits);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            r = {r[62:0], lfsr_step()};
        end
        return r;
    endfunction

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d failed checks", tests_run, name, errors - errs_before);
        end
    endtask

    // one packet closed by push on the last word or by the almost-full level
    task automatic send_packet(input int len, input bit use_push);
        logic [ft601_pkg::WORD_W-1:0] word;
        logic big;
        big = (len >= ft601_pkg::AFULL_LEVEL);
        for (int i = 0; i < len; i++) begin
            @(posedge wr_clk);
            #1;
            assert (writeable) else begin
                errors++;
                $display("FAIL %0t writeable: got %b expected 1", $time, writeable);
            end
            word = ft601_pkg::WORD_W'(rand_bits(ft601_pkg::WORD_W));
            wr_data = word;
            wr_ce = 1'b1;
            wr_en = 1'b1;
            wr_push = use_push && (i == len - 1);
            exp_q.push_back(word);
        end
        @(posedge wr_clk);
        #1;
        wr_ce = 1'b0;
        wr_en = 1'b0;
        wr_push = 1'b0;
        assert (!writeable) else begin
            errors++;
            $display("FAIL %0t writeable: got %b expected 0", $time, writeable);
        end
        assert (almost_unwriteable == big) else begin
            errors++;
            $display("FAIL %0t almost_unwriteable: got %b expected %b", $time,
                almost_unwriteable, big);
        end
        assert (wr_afull == big) else begin
            errors++;
            $display("FAIL %0t wr_afull: got %b expected %b", $time, wr_afull, big);
        end
        while (!writeable) begin
            @(posedge wr_clk);
            #1;
        end
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("writeable came back with %0d words still unsent at %0t",
                exp_q.size(), $time);
        end
        assert (!almost_unwriteable) else begin
            errors++;
            $display("FAIL %0t almost_unwriteable: got 1 expected 0", $time);
        end
    endtask

    // FT601 side stalls at random only while stall_en
    always @(posedge rd_clk) begin
        #1;
        if (stall_en) begin
            ft_txe_n = (rand_bits(2) == 64'd0);
        end else begin
            ft_txe_n = 1'b0;
        end
    end

    always @(negedge rd_clk) begin
        txe_at_fall <= ft_txe_n;
    end

    // sink model takes a word when txe_n and wr_n are both low at the rising edge
    always @(posedge rd_clk) begin
        if (!rd_reset && txe_at_fall === 1'b1) begin
            assert (ft_wr_n) else begin
                errors++;
                $display("FAIL %0t ft_wr_n: got %b expected 1", $time, ft_wr_n);
            end
        end
        if (!rd_reset && ft_txe_n === 1'b0 && ft_wr_n === 1'b0) begin
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("extra word %h accepted with nothing left to send at %0t",
                    {ft_be, ft_data}, $time);
            end
            if (exp_q.size() > 0) begin
                exp_word = exp_q.pop_front();
                words_seen++;
                assert (ft_data == exp_word[ft601_pkg::DATA_W-1:0]) else begin
                    errors++;
                    $display("FAIL %0t ft_data: got %h expected %h", $time, ft_data,
                        exp_word[ft601_pkg::DATA_W-1:0]);
                end
                assert (ft_be == exp_word[ft601_pkg::WORD_W-1:ft601_pkg::DATA_W]) else begin
                    errors++;
                    $display("FAIL %0t ft_be: got %h expected %h", $time, ft_be,
                        exp_word[ft601_pkg::WORD_W-1:ft601_pkg::DATA_W]);
                end
            end
        end
    end

    initial begin
        wait (budget_ns > 0);
        #(budget_ns);
        $display("timeout: run still going after %0d ns", budget_ns);
        $display("Errors found");
        $finish;
    end

    initial begin
        int errs_before;
        wr_reset = 1'b1;
        rd_reset = 1'b1;
        wr_data = '0;
        wr_ce = 1'b0;
        wr_en = 1'b0;
        wr_push = 1'b0;
        ft_txe_n = 1'b0;
        stall_en = 1'b0;

        // lengths fixed up front so the watchdog can size itself
        pkt_len.push_back(6);
        pkt_len.push_back(1 + int'(rand_bits(4)));
        pkt_len.push_back(ft601_pkg::AFULL_LEVEL);
        pkt_len.push_back(1 + int'(rand_bits(7)));     // stalled pair
        pkt_len.push_back(1 + int'(rand_bits(7)));
        for (int i = 0; i < BURST_PKTS; i++) begin
            pkt_len.push_back(1 + int'(rand_bits(7)));
        end
        foreach (pkt_len[i]) begin
            total_words += pkt_len[i];
        end
        budget_ns = 4 * total_words * RD_PERIOD + MARGIN_NS;

        fork
            begin
                repeat (RESET_CYCLES) @(posedge wr_clk);
                #1;
                wr_reset = 1'b0;
            end
            begin
                repeat (RESET_CYCLES) @(posedge rd_clk);
                #1;
                rd_reset = 1'b0;
            end
        join
        repeat (4) @(posedge wr_clk);
        #1;

        errs_before = errors;
        assert (writeable) else begin
            errors++;
            $display("FAIL %0t writeable: got %b expected 1", $time, writeable);
        end
        assert (!almost_unwriteable) else begin
            errors++;
            $display("FAIL %0t almost_unwriteable: got %b expected 0", $time,
                almost_unwriteable);
        end
        assert (ft_wr_n) else begin
            errors++;
            $display("FAIL %0t ft_wr_n: got %b expected 1", $time, ft_wr_n);
        end
        end_test("reset values", errs_before);

        errs_before = errors;
        send_packet(pkt_len[0], 1'b1);
        end_test("short pushed packet", errs_before);

        errs_before = errors;
        send_packet(pkt_len[1], 1'b1);
        end_test("writeable held until drained", errs_before);

        errs_before = errors;
        send_packet(pkt_len[2], 1'b0);
        end_test("almost-full close", errs_before);

        errs_before = errors;
        stall_en = 1'b1;
        send_packet(pkt_len[3], 1'b1);
        send_packet(pkt_len[4], 1'b1);
        stall_en = 1'b0;
        end_test("random txe_n stalls", errs_before);

        errs_before = errors;
        for (int i = 5; i < pkt_len.size(); i++) begin
            send_packet(pkt_len[i], 1'b1);
        end
        end_test("back to back packets", errs_before);

        assert (words_seen == total_words) else begin
            errors++;
            $display("FAIL %0t words_seen: got %0d expected %0d", $time, words_seen,
                total_words);
        end
        $display("%0d tests, %0d failed, %0d words checked, %0d errors", tests_run,
            tests_failed, words_seen, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== project.f ====
source/ft601_pkg.sv
source/cdc_sync_bit.sv
source/async_fifo.sv
source/ft601_wr_buf.sv
source/ft601_tx_ctrl.sv
source/ft601_tx_top.sv
test/ft601_tx_tb.sv

// ==== Makefile ====
TB_TOP := ft601_tx_tb
RTL_TOP := ft601_tx_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(RTL_TOP) -f project.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TB_TOP) -Mdir obj_dir -f project.f
	@out="$$(./obj_dir/V$(TB_TOP))"; echo "$$out"; echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir
